/* hw/hb_pkg.sv */
package hb_pkg;

    localparam int SAMPLE_W = 16;
    localparam int COEF_W = 18;
    localparam int FRAC_BITS = 18;
    localparam int NUM_COEFS = 16;
    localparam int E0_TAPS = 32;
    localparam int E1_TAPS = 16;
    localparam int ACC_W = 54;
    localparam int TREE_LEVELS = 4;

    // Edges from a phase-0 acceptance to o_valid
    localparam int LATENCY = 7;
    // Centre tap hold, counted from the tap register to the rounding adder
    localparam int CENTER_DELAY = 6;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [SAMPLE_W:0] sum_t;
    typedef logic signed [COEF_W-1:0] coef_t;
    typedef logic signed [SAMPLE_W+COEF_W:0] prod_t;
    typedef logic signed [ACC_W-1:0] acc_t;

    typedef enum logic {
        PHASE_E0,
        PHASE_E1
    } phase_e;

    // Index k weights samples k and 31-k of the E0 window
    localparam coef_t COEFS [NUM_COEFS] = '{
        -18'sd122,
        18'sd187,
        -18'sd323,
        18'sd517,
        -18'sd785,
        18'sd1146,
        -18'sd1622,
        18'sd2243,
        -18'sd3051,
        18'sd4112,
        -18'sd5533,
        18'sd7520,
        -18'sd10511,
        18'sd16110,
        -18'sd27184,
        18'sd83231
    };

endpackage

/* hw/hb_phase_control.sv */
`timescale 1ns/1ps

module hb_phase_control (
    input  logic i_clock,
    input  logic i_reset,
    input  logic i_valid,
    output logic o_load_e0,
    output logic o_load_e1,
    output logic o_result_valid,
    output logic o_valid
);

    hb_pkg::phase_e phase;
    // Bit k is loaded on the k-th edge after the accepting edge
    logic [hb_pkg::LATENCY:0] valid_pipe;

    // First sample after reset goes to E0
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            phase <= hb_pkg::PHASE_E0;
        end else if (i_valid) begin
            phase <= (phase == hb_pkg::PHASE_E0) ? hb_pkg::PHASE_E1 : hb_pkg::PHASE_E0;
        end
    end

    assign o_load_e0 = i_valid && (phase == hb_pkg::PHASE_E0);
    assign o_load_e1 = i_valid && (phase == hb_pkg::PHASE_E1);

    // Only phase-0 samples produce an output
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[hb_pkg::LATENCY-1:0], o_load_e0};
        end
    end

    assign o_result_valid = valid_pipe[hb_pkg::LATENCY-1];
    assign o_valid = valid_pipe[hb_pkg::LATENCY];

endmodule

/* hw/hb_polyphase_taps.sv */
`timescale 1ns/1ps

module hb_polyphase_taps (
    input  logic            i_clock,
    input  logic            i_reset,
    input  hb_pkg::sample_t i_data,
    input  logic            i_load_e0,
    input  logic            i_load_e1,
    output hb_pkg::sum_t    o_sums [hb_pkg::NUM_COEFS],
    output hb_pkg::sample_t o_center
);

    // Incoming sample is window entry 0, so E0 stores one less
    hb_pkg::sample_t e0_line [hb_pkg::E0_TAPS-1];
    hb_pkg::sample_t e1_line [hb_pkg::E1_TAPS];
    hb_pkg::sample_t window [hb_pkg::E0_TAPS];

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int j = 0; j < hb_pkg::E0_TAPS - 1; j++) begin
                e0_line[j] <= '0;
            end
            for (int j = 0; j < hb_pkg::E1_TAPS; j++) begin
                e1_line[j] <= '0;
            end
        end else begin
            if (i_load_e0) begin
                e0_line[0] <= i_data;
                for (int j = 1; j < hb_pkg::E0_TAPS - 1; j++) begin
                    e0_line[j] <= e0_line[j-1];
                end
            end
            if (i_load_e1) begin
                e1_line[0] <= i_data;
                for (int j = 1; j < hb_pkg::E1_TAPS; j++) begin
                    e1_line[j] <= e1_line[j-1];
                end
            end
        end
    end

    always_comb begin
        window[0] = i_data;
        for (int j = 1; j < hb_pkg::E0_TAPS; j++) begin
            window[j] = e0_line[j-1];
        end
    end

    // Symmetric preadders, one bit of growth
    always_ff @(posedge i_clock) begin
        if (i_load_e0) begin
            for (int k = 0; k < hb_pkg::NUM_COEFS; k++) begin
                o_sums[k] <= hb_pkg::sum_t'(window[k])
                           + hb_pkg::sum_t'(window[hb_pkg::E0_TAPS-1-k]);
            end
            // Oldest E1 sample is the centre tap
            o_center <= e1_line[hb_pkg::E1_TAPS-1];
        end
    end

endmodule

/* hw/hb_symmetric_mac.sv */
`timescale 1ns/1ps

module hb_symmetric_mac (
    input  logic         i_clock,
    input  hb_pkg::sum_t i_sums [hb_pkg::NUM_COEFS],
    output hb_pkg::acc_t o_acc
);

    hb_pkg::prod_t prod [hb_pkg::NUM_COEFS];

    // Tree nodes packed level after level: 8, 4, 2, then the root
    hb_pkg::acc_t node [hb_pkg::NUM_COEFS-1];

    always_ff @(posedge i_clock) begin
        for (int k = 0; k < hb_pkg::NUM_COEFS; k++) begin
            prod[k] <= hb_pkg::COEFS[k] * i_sums[k];
        end
    end

    always_ff @(posedge i_clock) begin
        for (int n = 0; n < hb_pkg::NUM_COEFS / 2; n++) begin
            node[n] <= hb_pkg::acc_t'(prod[2*n]) + hb_pkg::acc_t'(prod[2*n+1]);
        end
        for (int lvl = 1; lvl < hb_pkg::TREE_LEVELS; lvl++) begin
            for (int n = 0; n < (hb_pkg::NUM_COEFS >> (lvl + 1)); n++) begin
                node[hb_pkg::NUM_COEFS - (hb_pkg::NUM_COEFS >> lvl) + n] <=
                    node[hb_pkg::NUM_COEFS - (hb_pkg::NUM_COEFS >> (lvl - 1)) + 2*n]
                  + node[hb_pkg::NUM_COEFS - (hb_pkg::NUM_COEFS >> (lvl - 1)) + 2*n + 1];
            end
        end
    end

    assign o_acc = node[hb_pkg::NUM_COEFS-2];

endmodule

/* hw/hb_round_saturate.sv */
`timescale 1ns/1ps

module hb_round_saturate (
    input  logic            i_clock,
    input  hb_pkg::acc_t    i_acc,
    input  hb_pkg::sample_t i_center,
    input  logic            i_result_valid,
    output hb_pkg::sample_t o_data
);

    // The tap register in front is the first stage of the hold
    hb_pkg::sample_t center_pipe [hb_pkg::CENTER_DELAY-1];
    hb_pkg::acc_t round_sum;
    logic [hb_pkg::ACC_W-hb_pkg::SAMPLE_W-hb_pkg::FRAC_BITS:0] round_top;

    always_ff @(posedge i_clock) begin
        center_pipe[0] <= i_center;
        for (int i = 1; i < hb_pkg::CENTER_DELAY - 1; i++) begin
            center_pipe[i] <= center_pipe[i-1];
        end
    end

    // Centre tap is worth one half, plus half an LSB for round half-up
    always_ff @(posedge i_clock) begin
        round_sum <= i_acc
                   + (hb_pkg::acc_t'(center_pipe[hb_pkg::CENTER_DELAY-2])
                      <<< (hb_pkg::FRAC_BITS - 1))
                   + (hb_pkg::acc_t'(1) <<< (hb_pkg::FRAC_BITS - 1));
    end

    // Bits above the output sample, including its sign bit
    assign round_top = round_sum[hb_pkg::ACC_W-1:hb_pkg::SAMPLE_W+hb_pkg::FRAC_BITS-1];

    always_ff @(posedge i_clock) begin
        if (i_result_valid) begin
            if (!round_top[$high(round_top)] && (|round_top)) begin
                o_data <= {1'b0, {(hb_pkg::SAMPLE_W-1){1'b1}}};
            end else if (round_top[$high(round_top)] && !(&round_top)) begin
                o_data <= {1'b1, {(hb_pkg::SAMPLE_W-1){1'b0}}};
            end else begin
                o_data <= round_sum[hb_pkg::SAMPLE_W+hb_pkg::FRAC_BITS-1:hb_pkg::FRAC_BITS];
            end
        end
    end

endmodule

/* hw/hb_decim_fir.sv */
`timescale 1ns/1ps

module hb_decim_fir (
    input  logic            i_clock,
    input  logic            i_reset,
    input  hb_pkg::sample_t i_inph_data,
    input  hb_pkg::sample_t i_quad_data,
    input  logic            i_valid,
    output hb_pkg::sample_t o_inph_data,
    output hb_pkg::sample_t o_quad_data,
    output logic            o_valid
);

    logic load_e0;
    logic load_e1;
    logic result_valid;

    hb_pkg::sum_t inph_sums [hb_pkg::NUM_COEFS];
    hb_pkg::sum_t quad_sums [hb_pkg::NUM_COEFS];
    hb_pkg::sample_t inph_center;
    hb_pkg::sample_t quad_center;
    hb_pkg::acc_t inph_acc;
    hb_pkg::acc_t quad_acc;

    hb_phase_control u_phase_control (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_valid        (i_valid),
        .o_load_e0      (load_e0),
        .o_load_e1      (load_e1),
        .o_result_valid (result_valid),
        .o_valid        (o_valid)
    );

    // In-phase rail
    hb_polyphase_taps u_inph_taps (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_data    (i_inph_data),
        .i_load_e0 (load_e0),
        .i_load_e1 (load_e1),
        .o_sums    (inph_sums),
        .o_center  (inph_center)
    );

    hb_symmetric_mac u_inph_mac (
        .i_clock (i_clock),
        .i_sums  (inph_sums),
        .o_acc   (inph_acc)
    );

    hb_round_saturate u_inph_round (
        .i_clock        (i_clock),
        .i_acc          (inph_acc),
        .i_center       (inph_center),
        .i_result_valid (result_valid),
        .o_data         (o_inph_data)
    );

    // Quadrature rail
    hb_polyphase_taps u_quad_taps (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_data    (i_quad_data),
        .i_load_e0 (load_e0),
        .i_load_e1 (load_e1),
        .o_sums    (quad_sums),
        .o_center  (quad_center)
    );

    hb_symmetric_mac u_quad_mac (
        .i_clock (i_clock),
        .i_sums  (quad_sums),
        .o_acc   (quad_acc)
    );

    hb_round_saturate u_quad_round (
        .i_clock        (i_clock),
        .i_acc          (quad_acc),
        .i_center       (quad_center),
        .i_result_valid (result_valid),
        .o_data         (o_quad_data)
    );

endmodule

/* dv/hb_decim_fir_tb.sv */
`timescale 1ns/1ps

module hb_decim_fir_tb;

    localparam string STIM_FILE = "dv/hb_decim_fir_stimulus.txt";

    logic            i_clock;
    logic            i_reset;
    hb_pkg::sample_t i_inph_data;
    hb_pkg::sample_t i_quad_data;
    logic            i_valid;
    hb_pkg::sample_t o_inph_data;
    hb_pkg::sample_t o_quad_data;
    logic            o_valid;

    // Parsed stimulus records
    byte   rec_tag [$];
    int    rec_a [$];
    int    rec_b [$];
    int    rec_c [$];
    string rec_name [$];

    hb_pkg::sample_t exp_inph_q [$];
    hb_pkg::sample_t exp_quad_q [$];
    int              accept_q [$];

    int              cycle = 0;
    int              accepted = 0;
    string           test_name = "none";
    logic            loaded = 1'b0;
    logic            have_last = 1'b0;
    hb_pkg::sample_t last_inph;
    hb_pkg::sample_t last_quad;

    hb_decim_fir DUT (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_inph_data (i_inph_data),
        .i_quad_data (i_quad_data),
        .i_valid     (i_valid),
        .o_inph_data (o_inph_data),
        .o_quad_data (o_quad_data),
        .o_valid     (o_valid)
    );

    initial begin
        i_clock = 1'b0;
        forever #2 i_clock = ~i_clock;
    end

    always @(posedge i_clock) begin
        cycle++;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_sample(input string what, input hb_pkg::sample_t expected,
                                input hb_pkg::sample_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("Mismatch in %s (%s): expected %0d, actual %0d",
                               test_name, what, expected, actual));
        end
    endtask

    task automatic check_latency(input int expected, input int actual);
        if (actual != expected) begin
            fail_run($sformatf("Mismatch in %s (latency): expected %0d, actual %0d",
                               test_name, expected, actual));
        end
    endtask

    task automatic read_stimulus();
        int    fd;
        string line;
        string name;
        byte   tag;
        int    a;
        int    b;
        int    c;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            fail_run("Could not open the stimulus file");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0) continue;
            tag = line.getc(0);
            a = 0;
            b = 0;
            c = 0;
            name = "";
            if (tag == "T") void'($sscanf(line, "T %s", name));
            else if (tag == "S") void'($sscanf(line, "S %d %d %d", a, b, c));
            else if (tag == "E") void'($sscanf(line, "E %d %d", a, b));
            else continue;
            rec_tag.push_back(tag);
            rec_a.push_back(a);
            rec_b.push_back(b);
            rec_c.push_back(c);
            rec_name.push_back(name);
        end
        $fclose(fd);
    endtask

    task automatic apply_reset();
        @(posedge i_clock);
        #1;
        i_reset = 1'b1;
        i_valid = 1'b0;
        repeat (8) @(posedge i_clock);
        #1;
        i_reset = 1'b0;
    endtask

    // One sample, then the file's gap plus a random extra gap
    task automatic drive_sample(input int inph, input int quad, input int gap);
        int idle;
        idle = gap + int'($urandom_range(2));
        @(posedge i_clock);
        #1;
        i_valid = 1'b1;
        i_inph_data = hb_pkg::sample_t'(inph);
        i_quad_data = hb_pkg::sample_t'(quad);
        repeat (idle) begin
            @(posedge i_clock);
            #1;
            i_valid = 1'b0;
        end
    endtask

    task automatic end_stream();
        @(posedge i_clock);
        #1;
        i_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_inph_q.size() != 0 && n < 64) begin
            @(posedge i_clock);
            n++;
        end
        if (exp_inph_q.size() != 0) begin
            fail_run($sformatf("Test %s ended with %0d expected outputs that never arrived",
                               test_name, exp_inph_q.size()));
        end
    endtask

    // Outputs are sampled on the falling edge, half a cycle after they change
    always @(negedge i_clock) begin : monitor
        int start;
        if (i_reset) begin
            accepted = 0;
            accept_q.delete();
        end else begin
            if (o_valid) begin
                if (exp_inph_q.size() == 0) begin
                    fail_run($sformatf("Test %s: o_valid pulsed with no output expected",
                                       test_name));
                end
                if (accept_q.size() == 0) begin
                    fail_run("o_valid pulsed without a matching phase-0 input");
                end
                start = accept_q.pop_front();
                check_latency(hb_pkg::LATENCY, cycle - start);
                check_sample("inph", exp_inph_q.pop_front(), o_inph_data);
                check_sample("quad", exp_quad_q.pop_front(), o_quad_data);
                last_inph = o_inph_data;
                last_quad = o_quad_data;
                have_last = 1'b1;
            end else if (have_last) begin
                check_sample("inph hold", last_inph, o_inph_data);
                check_sample("quad hold", last_quad, o_quad_data);
            end
            if (i_valid) begin
                if (accepted % 2 == 0) accept_q.push_back(cycle + 1);
                accepted++;
            end
        end
    end

    initial begin
        i_reset = 1'b1;
        i_valid = 1'b0;
        i_inph_data = '0;
        i_quad_data = '0;
        void'($urandom(32'h67ad_be80));
        read_stimulus();
        loaded = 1'b1;
        for (int r = 0; r < rec_tag.size(); r++) begin
            if (rec_tag[r] == "T") begin
                end_stream();
                wait_drain();
                test_name = rec_name[r];
                apply_reset();
                for (int e = r + 1; e < rec_tag.size() && rec_tag[e] != "T"; e++) begin
                    if (rec_tag[e] == "E") begin
                        exp_inph_q.push_back(hb_pkg::sample_t'(rec_a[e]));
                        exp_quad_q.push_back(hb_pkg::sample_t'(rec_b[e]));
                    end
                end
            end else if (rec_tag[r] == "S") begin
                drive_sample(rec_a[r], rec_b[r], rec_c[r]);
            end
        end
        end_stream();
        wait_drain();
        repeat (hb_pkg::LATENCY + 4) @(posedge i_clock);
        $display("TB PASSED");
        $finish;
    end

    // Watchdog sized from the number of records
    initial begin
        wait (loaded);
        repeat (rec_tag.size() * 20 + 200) @(posedge i_clock);
        fail_run("Timeout: the run did not finish in the allowed number of cycles");
    end

endmodule

/* hb_decim_fir.f */
hw/hb_pkg.sv
hw/hb_phase_control.sv
hw/hb_polyphase_taps.sv
hw/hb_symmetric_mac.sv
hw/hb_round_saturate.sv
hw/hb_decim_fir.sv
dv/hb_decim_fir_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module hb_decim_fir_tb \
    -f hb_decim_fir.f \
    -o hb_decim_fir_sim

./obj_dir/hb_decim_fir_sim

/* dv/hb_decim_fir_stimulus.txt */
# T name | S inph quad idle_cycles | E expected_inph expected_quad
# E records of a test are queued at its reset, in output order
T impulse
S 16384 0 0
S 0 0 0
S 0 0 1
S 0 0 0
E -8 0
E 12 0
T dirty_lines
S 1000 0 0
S 2000 0 0
S 3000 0 0
E 0 0
E -1 0
T reset_restart
S 16384 0 2
S 0 0 0
S 0 0 0
S 0 0 3
E -8 0
E 12 0
T centre_and_rails
S 0 -16384 0
S 16384 0 1
S 0 0 0
S 0 0 0
S 0 0 2
S 0 0 0
S 0 0 0
S 0 0 0
S 0 0 1
S 0 0 0
S 0 0 0
S 0 0 0
S 0 0 0
S 0 0 3
S 0 0 0
S 0 0 0
S 0 0 0
S 0 0 0
S 0 0 0
S 0 0 1
S 0 0 0
S 0 0 0
S 0 0 0
S 0 0 0
S 0 0 2
S 0 0 0
S 0 0 0
S 0 0 0
S 0 0 0
S 0 0 0
S 0 0 1
S 0 0 0
S 0 0 0
E 0 8
E 0 -12
E 0 20
E 0 -32
E 0 49
E 0 -72
E 0 101
E 0 -140
E 0 191
E 0 -257
E 0 346
E 0 -470
E 0 657
E 0 -1007
E 0 1699
E 0 -5202
E 8192 -5202
T saturation
S 32767 -32768 0
S 32767 -32768 0
S 32767 -32768 0
S 32767 -32768 0
S 32767 -32768 0
S 32767 -32768 0
S 32767 -32768 0
S 32767 -32768 0
S 32767 -32768 0
S 32767 -32768 0
S 32767 -32768 0
S 32767 -32768 0
S 32767 -32768 0
S 32767 -32768 0
S 32767 -32768 0
S 32767 -32768 0
S 32767 -32768 0
S 32767 -32768 0
S 32767 -32768 0
S 32767 -32768 0
S 32767 -32768 0
S 32767 -32768 0
S 32767 -32768 0
S 32767 -32768 0
S 32767 -32768 0
S 32767 -32768 0
S 32767 -32768 0
S 32767 -32768 0
S 32767 -32768 0
S 32767 -32768 0
S 32767 -32768 0
S 32767 -32768 0
S 32767 -32768 0
E -15 15
E 8 -8
E -32 32
E 32 -32
E -66 66
E 77 -77
E -125 125
E 155 -155
E -226 226
E 288 -288
E -404 404
E 536 -536
E -778 778
E 1236 -1236
E -2162 2162
E 8242 -8242
E 32767 -32768
